// File: include/mem_slot_macros.svh
// Fixed sizes for the memory-access slot: bus word, address, page, tag and bus timeout
`ifndef MEM_SLOT_MACROS_SVH
`define MEM_SLOT_MACROS_SVH

// ============================================================
// Bus and address geometry
// ============================================================

// Bytes in one bus word
`define MS_DATA_BYTES 8
// Byte address width
`define MS_ADDR_BITS 32
// log2 of the page size, 4 KiB pages
`define MS_PAGE_BITS 12

// ============================================================
// Core side
// ============================================================

// Load/store queue tag width
`define MS_TAG_BITS 5
// Cycles one bus phase may wait before it is ended with a bus fault
`define MS_TIMEOUT 64

`endif

// File: logic/mem_slot_oper.sv
// Result assembly: read-word capture, merge and zero-extend, done pulse with tag and fault
`default_nettype none

`include "mem_slot_macros.svh"

module mem_slot_oper (
	input  wire                               clk_i,
	input  wire                               rst_i,
	input  wire                               capture_i,
	input  wire                               capture_hi_i,
	input  wire                               finish_i,
	input  mem_slot_pkg::fault_t              fault_i,
	input  mem_slot_pkg::data_t               mem_rdat_i,
	input  mem_slot_pkg::tag_t                tag_i,
	input  wire                               load_i,
	input  mem_slot_pkg::size_t               size_i,
	input  wire [$clog2(`MS_DATA_BYTES)-1:0]  offs_i,
	input  wire                               valid_i,
	output logic                              done_o,
	output mem_slot_pkg::tag_t                done_tag_o,
	output mem_slot_pkg::data_t               done_data_o,
	output mem_slot_pkg::fault_t              done_fault_o
);
	import mem_slot_pkg::*;

	data_t rd_lo_q;
	data_t rd_hi_q;
	wide_t merged;
	data_t result;

	// Low bytes kept for an access of 2**size bytes
	function automatic data_t fn_mask(input size_t size);
		data_t mask;
		mask = ~(data_t'('1) << (8 << size));
		return mask;
	endfunction

	// ============================================================
	// Read word capture
	// ============================================================
	always_ff @(posedge clk_i) begin
		if (capture_i) begin
			if (capture_hi_i)
				rd_hi_q <= mem_rdat_i;
			else
				rd_lo_q <= mem_rdat_i;
		end
	end

	// Bring the addressed byte down to lane zero
	// High word only contributes when the access spanned two words
	assign merged = {rd_hi_q, rd_lo_q} >> {offs_i, 3'b000};
	assign result = merged[`MS_DATA_BYTES*8-1:0] & fn_mask(size_i);

	// ============================================================
	// Done pulse
	// ============================================================
	always_ff @(posedge clk_i) begin
		if (rst_i)
			done_o <= 1'b0;
		else
			done_o <= finish_i && valid_i;
	end

	// Result payload, zero for stores and faulted accesses
	always_ff @(posedge clk_i) begin
		if (finish_i) begin
			done_tag_o   <= tag_i;
			done_fault_o <= fault_i;
			if (load_i && fault_i == FLT_NONE)
				done_data_o <= result;
			else
				done_data_o <= '0;
		end
	end

	// One result per access
	a_done_single: assert property (@(posedge clk_i) disable iff (rst_i)
		done_o |=> !done_o);

endmodule

`default_nettype wire

// File: logic/mem_slot_pkg.sv
// Shared types of the memory-access slot: vectors, slot states and fault codes
`default_nettype none

`include "mem_slot_macros.svh"

package mem_slot_pkg;

	// Byte address
	typedef logic [`MS_ADDR_BITS-1:0] addr_t;
	// One bus word
	typedef logic [`MS_DATA_BYTES*8-1:0] data_t;
	// Two bus words, store data after the lane shift
	typedef logic [2*`MS_DATA_BYTES*8-1:0] wide_t;
	// Byte lanes of one word
	typedef logic [`MS_DATA_BYTES-1:0] sel_t;
	// Byte lanes over the low and the high word
	typedef logic [2*`MS_DATA_BYTES-1:0] wsel_t;
	// Queue tag
	typedef logic [`MS_TAG_BITS-1:0] tag_t;
	// Access size, log2 of the byte count
	typedef logic [1:0] size_t;
	// Per-phase timeout counter
	typedef logic [7:0] tocnt_t;

	// Slot sequence, low word phase then optional high word phase
	typedef enum logic [2:0] {
		AVAIL   = 3'd0,
		ACTIVE  = 3'd1,
		DELAY   = 3'd2,
		ACTIVE2 = 3'd3,
		DELAY2  = 3'd4,
		FINISH  = 3'd5
	} slot_state_t;

	// Fault reported with the result
	typedef enum logic [1:0] {
		FLT_NONE = 2'd0,
		FLT_ALN  = 2'd1,
		FLT_BUS  = 2'd2
	} fault_t;

endpackage

`default_nettype wire

// File: logic/mem_slot_seq.sv
// Slot state machine: queue and bus four-phase handshakes, phase timeout, fault code
`default_nettype none

`include "mem_slot_macros.svh"

module mem_slot_seq (
	input  wire                       clk_i,
	input  wire                       rst_i,
	input  wire                       q_req_i,
	output logic                      q_ack_o,
	input  wire                       mem_ack_i,
	output logic                      mem_req_o,
	input  wire                       more_i,
	input  wire                       page_cross_i,
	output logic                      ld_o,
	output logic                      hi_o,
	output logic                      capture_o,
	output logic                      capture_hi_o,
	output logic                      finish_o,
	output mem_slot_pkg::fault_t      fault_o,
	output mem_slot_pkg::slot_state_t state_o
);
	import mem_slot_pkg::*;

	slot_state_t state_q;
	slot_state_t state_d;
	fault_t      fault_d;
	logic        req_d;
	tocnt_t      tocnt_q;
	logic        accept;
	logic        timeout;

	// New entry taken only once the previous ack has dropped
	assign accept  = (state_q == AVAIL) && q_req_i && !q_ack_o;
	assign timeout = (tocnt_q == tocnt_t'(`MS_TIMEOUT - 1));

	// ============================================================
	// Next state
	// ============================================================
	always_comb begin
		state_d = state_q;
		fault_d = fault_o;
		req_d   = mem_req_o;
		case (state_q)
			AVAIL: begin
				if (accept) begin
					state_d = ACTIVE;
					fault_d = FLT_NONE;
				end
			end
			ACTIVE, ACTIVE2: begin
				// Page crossing is known one cycle after capture, before any request
				if (state_q == ACTIVE && page_cross_i) begin
					state_d = FINISH;
					fault_d = FLT_ALN;
				end else if (mem_req_o && mem_ack_i) begin
					req_d   = 1'b0;
					state_d = (state_q == ACTIVE) ? DELAY : DELAY2;
				end else if (timeout) begin
					// Drop the request and wait out the ack like a last phase
					req_d   = 1'b0;
					fault_d = FLT_BUS;
					state_d = DELAY2;
				end else if (!mem_req_o && !mem_ack_i) begin
					req_d = 1'b1;
				end
			end
			DELAY: begin
				if (!mem_ack_i) begin
					state_d = more_i ? ACTIVE2 : FINISH;
				end else if (timeout) begin
					fault_d = FLT_BUS;
					state_d = FINISH;
				end
			end
			DELAY2: begin
				if (!mem_ack_i) begin
					state_d = FINISH;
				end else if (timeout) begin
					fault_d = FLT_BUS;
					state_d = FINISH;
				end
			end
			FINISH: state_d = AVAIL;
			default: state_d = AVAIL;
		endcase
	end

	// ============================================================
	// State, handshake and timeout registers
	// ============================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q   <= AVAIL;
			fault_o   <= FLT_NONE;
			mem_req_o <= 1'b0;
			q_ack_o   <= 1'b0;
			tocnt_q   <= '0;
		end else begin
			state_q   <= state_d;
			fault_o   <= fault_d;
			mem_req_o <= req_d;
			// Queue ack follows req down one cycle later
			if (accept)
				q_ack_o <= 1'b1;
			else if (q_ack_o && !q_req_i)
				q_ack_o <= 1'b0;
			// Count cycles spent in one state
			if (state_d != state_q)
				tocnt_q <= '0;
			else if (state_q != AVAIL)
				tocnt_q <= tocnt_q + tocnt_t'(1);
		end
	end

	// Strobes to the work and result blocks
	assign ld_o         = accept;
	assign hi_o         = (state_q == DELAY) && !mem_ack_i && more_i;
	assign capture_o    = (state_q == ACTIVE || state_q == ACTIVE2) && mem_req_o && mem_ack_i;
	assign capture_hi_o = (state_q == ACTIVE2);
	assign finish_o     = (state_q == FINISH);
	assign state_o      = state_q;

	// A new bus request only after memory has released the previous ack
	a_req_after_ack_low: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(mem_req_o) |-> !$past(mem_ack_i));

	// Queue ack rises only on the step out of AVAIL
	a_ack_from_avail: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(q_ack_o) |-> (state_q == ACTIVE) && ($past(state_q) == AVAIL));

endmodule

`default_nettype wire

// File: logic/mem_slot_top.sv
// Memory-access slot top: state machine, work register and result assembly
`default_nettype none

`include "mem_slot_macros.svh"

module mem_slot_top (
	input  wire                  clk_i,
	input  wire                  rst_i,
	// Load/store queue
	input  wire                  q_req_i,
	output logic                 q_ack_o,
	input  mem_slot_pkg::tag_t   q_tag_i,
	input  wire                  q_load_i,
	input  mem_slot_pkg::size_t  q_size_i,
	input  mem_slot_pkg::addr_t  q_addr_i,
	input  mem_slot_pkg::data_t  q_wdata_i,
	// Memory bus
	output logic                 mem_req_o,
	input  wire                  mem_ack_i,
	output logic                 mem_we_o,
	output mem_slot_pkg::addr_t  mem_adr_o,
	output mem_slot_pkg::sel_t   mem_sel_o,
	output mem_slot_pkg::data_t  mem_wdat_o,
	input  mem_slot_pkg::data_t  mem_rdat_i,
	// Flush
	input  wire                  stomp_i,
	input  mem_slot_pkg::tag_t   stomp_tag_i,
	// Result
	output logic                 done_o,
	output mem_slot_pkg::tag_t   done_tag_o,
	output mem_slot_pkg::data_t  done_data_o,
	output mem_slot_pkg::fault_t done_fault_o
);
	import mem_slot_pkg::*;

	logic                             ld;
	logic                             hi;
	logic                             capture;
	logic                             capture_hi;
	logic                             finish;
	fault_t                           fault;
	tag_t                             tag;
	logic                             load;
	size_t                            size;
	logic [$clog2(`MS_DATA_BYTES)-1:0] offs;
	logic                             valid;
	logic                             more;
	logic                             page_cross;

	// State output left open, observed only from simulation
	mem_slot_seq i_seq (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.q_req_i      (q_req_i),
		.q_ack_o      (q_ack_o),
		.mem_ack_i    (mem_ack_i),
		.mem_req_o    (mem_req_o),
		.more_i       (more),
		.page_cross_i (page_cross),
		.ld_o         (ld),
		.hi_o         (hi),
		.capture_o    (capture),
		.capture_hi_o (capture_hi),
		.finish_o     (finish),
		.fault_o      (fault),
		.state_o      ()
	);

	mem_slot_work i_work (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.ld_i         (ld),
		.hi_i         (hi),
		.q_tag_i      (q_tag_i),
		.q_load_i     (q_load_i),
		.q_size_i     (q_size_i),
		.q_addr_i     (q_addr_i),
		.q_wdata_i    (q_wdata_i),
		.stomp_i      (stomp_i),
		.stomp_tag_i  (stomp_tag_i),
		.tag_o        (tag),
		.load_o       (load),
		.size_o       (size),
		.offs_o       (offs),
		.valid_o      (valid),
		.more_o       (more),
		.page_cross_o (page_cross),
		.mem_we_o     (mem_we_o),
		.mem_adr_o    (mem_adr_o),
		.mem_sel_o    (mem_sel_o),
		.mem_wdat_o   (mem_wdat_o)
	);

	mem_slot_oper i_oper (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.capture_i    (capture),
		.capture_hi_i (capture_hi),
		.finish_i     (finish),
		.fault_i      (fault),
		.mem_rdat_i   (mem_rdat_i),
		.tag_i        (tag),
		.load_i       (load),
		.size_i       (size),
		.offs_i       (offs),
		.valid_i      (valid),
		.done_o       (done_o),
		.done_tag_o   (done_tag_o),
		.done_data_o  (done_data_o),
		.done_fault_o (done_fault_o)
	);

endmodule

`default_nettype wire

// File: logic/mem_slot_work.sv
// Work register: captured queue entry, byte selects, lane-shifted store data, high-half step
`default_nettype none

`include "mem_slot_macros.svh"

module mem_slot_work (
	input  wire                                  clk_i,
	input  wire                                  rst_i,
	input  wire                                  ld_i,
	input  wire                                  hi_i,
	input  mem_slot_pkg::tag_t                   q_tag_i,
	input  wire                                  q_load_i,
	input  mem_slot_pkg::size_t                  q_size_i,
	input  mem_slot_pkg::addr_t                  q_addr_i,
	input  mem_slot_pkg::data_t                  q_wdata_i,
	input  wire                                  stomp_i,
	input  mem_slot_pkg::tag_t                   stomp_tag_i,
	output mem_slot_pkg::tag_t                   tag_o,
	output logic                                 load_o,
	output mem_slot_pkg::size_t                  size_o,
	output logic [$clog2(`MS_DATA_BYTES)-1:0]    offs_o,
	output logic                                 valid_o,
	output logic                                 more_o,
	output logic                                 page_cross_o,
	output logic                                 mem_we_o,
	output mem_slot_pkg::addr_t                  mem_adr_o,
	output mem_slot_pkg::sel_t                   mem_sel_o,
	output mem_slot_pkg::data_t                  mem_wdat_o
);
	import mem_slot_pkg::*;

	localparam int OFFS_BITS = $clog2(`MS_DATA_BYTES);

	logic [OFFS_BITS-1:0] q_offs;
	wsel_t                q_wsel;
	wide_t                q_wide;
	addr_t                next_adr;
	sel_t                 sel_hi_q;
	data_t                wdat_hi_q;
	logic                 hi_q;

	// Lanes covered by an access of 2**size bytes at lane zero
	function automatic sel_t fn_sel(input size_t size);
		sel_t mask;
		mask = ~(sel_t'('1) << (1 << size));
		return mask;
	endfunction

	// ============================================================
	// Lane placement of the incoming entry
	// ============================================================
	assign q_offs = q_addr_i[OFFS_BITS-1:0];

	// Selects and data slide up by the byte offset, spilling into the high word
	assign q_wsel = wsel_t'(fn_sel(q_size_i)) << q_offs;
	assign q_wide = wide_t'(q_wdata_i) << {q_offs, 3'b000};

	// Control state of the slot entry
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_o <= 1'b0;
			hi_q    <= 1'b0;
		end else if (ld_i) begin
			// An entry stomped while being handed over never becomes valid
			valid_o <= !(stomp_i && stomp_tag_i == q_tag_i);
			hi_q    <= 1'b0;
		end else begin
			if (hi_i)
				hi_q <= 1'b1;
			// Flush of the held tag, bus cycle still runs to its end
			if (stomp_i && stomp_tag_i == tag_o)
				valid_o <= 1'b0;
		end
	end

	// ============================================================
	// Payload, low word on capture and high word on advance
	// ============================================================
	always_ff @(posedge clk_i) begin
		if (ld_i) begin
			tag_o      <= q_tag_i;
			load_o     <= q_load_i;
			size_o     <= q_size_i;
			offs_o     <= q_offs;
			mem_we_o   <= !q_load_i;
			// Bus address is always word aligned
			mem_adr_o  <= {q_addr_i[`MS_ADDR_BITS-1:OFFS_BITS], {OFFS_BITS{1'b0}}};
			mem_sel_o  <= q_wsel[`MS_DATA_BYTES-1:0];
			sel_hi_q   <= q_wsel[2*`MS_DATA_BYTES-1:`MS_DATA_BYTES];
			mem_wdat_o <= q_wide[`MS_DATA_BYTES*8-1:0];
			wdat_hi_q  <= q_wide[2*`MS_DATA_BYTES*8-1:`MS_DATA_BYTES*8];
		end else if (hi_i) begin
			mem_adr_o  <= next_adr;
			mem_sel_o  <= sel_hi_q;
			mem_wdat_o <= wdat_hi_q;
		end
	end

	// Word after the current one
	assign next_adr = mem_adr_o + addr_t'(`MS_DATA_BYTES);

	// Second phase needed while upper lanes remain and the step has not been taken
	assign more_o = |sel_hi_q && !hi_q;

	// Upper lanes land in the next page
	assign page_cross_o = more_o &&
		(next_adr[`MS_ADDR_BITS-1:`MS_PAGE_BITS] != mem_adr_o[`MS_ADDR_BITS-1:`MS_PAGE_BITS]);

endmodule

`default_nettype wire

// File: sim/mem_slot_checker.sv
// Result checker: done-port comparison against queued expectations, bus request count, test lines
`default_nettype none

module mem_slot_checker (
	input  wire                  clk_i,
	input  wire                  rst_i,
	input  wire                  mem_req_i,
	input  wire                  done_i,
	input  mem_slot_pkg::tag_t   done_tag_i,
	input  mem_slot_pkg::data_t  done_data_i,
	input  mem_slot_pkg::fault_t done_fault_i
);
	timeunit 1ns;
	timeprecision 100ps;

	import mem_slot_pkg::*;

	// Results still owed by the DUT, oldest first
	tag_t   exp_tag_q[$];
	data_t  exp_data_q[$];
	fault_t exp_fault_q[$];

	logic req_prev     = 1'b0;
	int   req_rises    = 0;
	int   req_base     = 0;
	int   test_errs    = 0;
	int   tests_run    = 0;
	int   tests_failed = 0;
	int   errors       = 0;

	task automatic expect_result(input tag_t tag, input data_t data, input fault_t fault);
		exp_tag_q.push_back(tag);
		exp_data_q.push_back(data);
		exp_fault_q.push_back(fault);
	endtask

	// Failure that is not a wrong value
	task automatic report_problem(input string what);
		$display("** Failure: %s", what);
		test_errs++;
		errors++;
	endtask

	task automatic value_error(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("** Error: %s = %h, expected %h", name, got, exp);
		test_errs++;
		errors++;
	endtask

	// ============================================================
	// Compare each done pulse with the oldest expectation
	// ============================================================
	always @(posedge clk_i) begin
		if (rst_i) begin
			req_prev = 1'b0;
		end else begin
			// Count bus phases by request rises
			if (mem_req_i && !req_prev)
				req_rises++;
			req_prev = mem_req_i;
			if (done_i && exp_tag_q.size() == 0) begin
				report_problem($sformatf("done_o pulsed with tag %h while no result was due",
					done_tag_i));
			end else if (done_i) begin
				if (done_tag_i !== exp_tag_q[0])
					value_error("done_tag_o", done_tag_i, exp_tag_q[0]);
				if (done_fault_i !== exp_fault_q[0])
					value_error("done_fault_o", done_fault_i, exp_fault_q[0]);
				if (done_data_i !== exp_data_q[0])
					value_error("done_data_o", done_data_i, exp_data_q[0]);
				void'(exp_tag_q.pop_front());
				void'(exp_data_q.pop_front());
				void'(exp_fault_q.pop_front());
			end
		end
	end

	task automatic begin_test();
		test_errs = 0;
		req_base  = req_rises;
	endtask

	// A negative request count means the count is not checked
	task automatic end_test(input string name, input int reqs);
		if (exp_tag_q.size() != 0) begin
			report_problem($sformatf("%0d expected results never arrived", exp_tag_q.size()));
			exp_tag_q.delete();
			exp_data_q.delete();
			exp_fault_q.delete();
		end
		if (reqs >= 0 && req_rises - req_base != reqs)
			report_problem($sformatf("%0d bus requests seen where %0d were due",
				req_rises - req_base, reqs));
		tests_run++;
		if (test_errs == 0) begin
			$display("Test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: %0d errors", tests_run, name, test_errs);
		end
	endtask

	task automatic print_counts();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
	endtask

	function automatic int error_total();
		return errors;
	endfunction

endmodule

`default_nettype wire

// File: sim/tb_mem_slot.sv
// Testbench top: clock and reset, queue driver, bus memory model, reference model, test sequence
`default_nettype none

`include "mem_slot_macros.svh"

module tb_mem_slot;
	timeunit 1ns;
	timeprecision 100ps;

	import mem_slot_pkg::*;

	localparam int MEM_BYTES  = 16384;
	localparam int WAIT_LIMIT = 4 * `MS_TIMEOUT;
	localparam int SIG_QACK   = 0;
	localparam int SIG_MREQ   = 1;
	localparam int SIG_DONE   = 2;

	logic   clk_i;
	logic   rst_i;
	logic   q_req_i;
	logic   q_ack_o;
	tag_t   q_tag_i;
	logic   q_load_i;
	size_t  q_size_i;
	addr_t  q_addr_i;
	data_t  q_wdata_i;
	logic   mem_req_o;
	logic   mem_ack_i;
	logic   mem_we_o;
	addr_t  mem_adr_o;
	sel_t   mem_sel_o;
	data_t  mem_wdat_o;
	data_t  mem_rdat_i;
	logic   stomp_i;
	tag_t   stomp_tag_i;
	logic   done_o;
	tag_t   done_tag_o;
	data_t  done_data_o;
	fault_t done_fault_o;

	integer     seed = 94259;
	integer     mem_delay;
	integer     lane;
	logic       mem_pend;
	data_t      rd;
	tag_t       next_tag;
	// Bus model image and the image expected from the access rules
	logic [7:0] model_mem [0:MEM_BYTES-1];
	logic [7:0] shadow_mem [0:MEM_BYTES-1];

	mem_slot_top i_dut (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.q_req_i      (q_req_i),
		.q_ack_o      (q_ack_o),
		.q_tag_i      (q_tag_i),
		.q_load_i     (q_load_i),
		.q_size_i     (q_size_i),
		.q_addr_i     (q_addr_i),
		.q_wdata_i    (q_wdata_i),
		.mem_req_o    (mem_req_o),
		.mem_ack_i    (mem_ack_i),
		.mem_we_o     (mem_we_o),
		.mem_adr_o    (mem_adr_o),
		.mem_sel_o    (mem_sel_o),
		.mem_wdat_o   (mem_wdat_o),
		.mem_rdat_i   (mem_rdat_i),
		.stomp_i      (stomp_i),
		.stomp_tag_i  (stomp_tag_i),
		.done_o       (done_o),
		.done_tag_o   (done_tag_o),
		.done_data_o  (done_data_o),
		.done_fault_o (done_fault_o)
	);

	mem_slot_checker i_chk (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.mem_req_i    (mem_req_o),
		.done_i       (done_o),
		.done_tag_i   (done_tag_o),
		.done_data_i  (done_data_o),
		.done_fault_i (done_fault_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	// Power-up contents, spread over the whole address
	function automatic logic [7:0] fill_byte(input addr_t a);
		addr_t h;
		h = a * 32'h9e37_79b1;
		return h[31:24];
	endfunction

	// ============================================================
	// Bus memory model, random ack delay, upper half unmapped
	// ============================================================
	always @(posedge clk_i) begin
		if (rst_i) begin
			mem_ack_i <= 1'b0;
			mem_pend  <= 1'b0;
		end else if (mem_ack_i) begin
			// Ack held until the request drops
			if (!mem_req_o)
				mem_ack_i <= 1'b0;
		end else if (mem_req_o && !mem_adr_o[31] && !mem_pend) begin
			mem_pend  <= 1'b1;
			mem_delay = {$random(seed)} % 6;
		end else if (mem_pend && mem_delay > 0) begin
			mem_delay = mem_delay - 1;
		end else if (mem_pend) begin
			mem_pend  <= 1'b0;
			mem_ack_i <= 1'b1;
			for (lane = 0; lane < `MS_DATA_BYTES; lane++) begin
				if (!mem_we_o)
					rd[lane*8 +: 8] = model_mem[mem_adr_o[13:0] + lane];
				else if (mem_sel_o[lane])
					model_mem[mem_adr_o[13:0] + lane] = mem_wdat_o[lane*8 +: 8];
			end
			mem_rdat_i <= rd;
		end
	end

	// Expected fault and load data, stores update the expected image
	function automatic fault_t expected_result(input logic load, input size_t size,
		input addr_t addr, input data_t wdata, output data_t data);
		addr_t last;
		int    i;
		last = addr + addr_t'((1 << size) - 1);
		data = '0;
		// First and last byte in different 4 KiB pages
		if (addr[`MS_ADDR_BITS-1:`MS_PAGE_BITS] != last[`MS_ADDR_BITS-1:`MS_PAGE_BITS])
			return FLT_ALN;
		if (addr[`MS_ADDR_BITS-1])
			return FLT_BUS;
		for (i = 0; i < (1 << size); i++) begin
			if (load)
				data[i*8 +: 8] = shadow_mem[addr[13:0] + i];
			else
				shadow_mem[addr[13:0] + i] = wdata[i*8 +: 8];
		end
		return FLT_NONE;
	endfunction

	// Bytes written over the bus against the expected image
	task automatic compare_images();
		int k;
		for (k = 0; k < MEM_BYTES; k++) begin
			if (model_mem[k] !== shadow_mem[k])
				i_chk.value_error($sformatf("model_mem[%0h]", k), model_mem[k],
					shadow_mem[k]);
		end
	endtask

	// Bounded wait for one DUT output to reach a level
	task automatic wait_level(input int sig, input logic level, input string what);
		int   cnt;
		logic seen;
		cnt  = 0;
		seen = ~level;
		while (seen !== level && cnt < WAIT_LIMIT) begin
			@(posedge clk_i);
			case (sig)
				SIG_QACK: seen = q_ack_o;
				SIG_MREQ: seen = mem_req_o;
				default:  seen = done_o;
			endcase
			cnt++;
		end
		if (seen !== level)
			i_chk.report_problem({"timeout while waiting for ", what});
	endtask

	task automatic run_access(input logic load, input size_t size, input addr_t addr,
		input data_t wdata, input bit stomp_it);
		data_t  exp_data;
		fault_t exp_fault;
		tag_t   tag;
		tag       = next_tag;
		next_tag  = next_tag + tag_t'(1);
		exp_fault = expected_result(load, size, addr, wdata, exp_data);
		// A stomped access owes no result
		if (!stomp_it)
			i_chk.expect_result(tag, exp_data, exp_fault);
		@(posedge clk_i);
		q_req_i   <= 1'b1;
		q_tag_i   <= tag;
		q_load_i  <= load;
		q_size_i  <= size;
		q_addr_i  <= addr;
		q_wdata_i <= wdata;
		wait_level(SIG_QACK, 1'b1, "q_ack_o to rise");
		q_req_i <= 1'b0;
		if (stomp_it) begin
			// Flush the tag while its first bus phase is open
			wait_level(SIG_MREQ, 1'b1, "mem_req_o to rise");
			stomp_i     <= 1'b1;
			stomp_tag_i <= tag;
			@(posedge clk_i);
			stomp_i <= 1'b0;
			wait_level(SIG_QACK, 1'b0, "q_ack_o to fall");
		end else begin
			wait_level(SIG_DONE, 1'b1, "done_o");
		end
	endtask

	// Let the checker see the last done before the test line
	task automatic close_test(input string name, input int reqs);
		@(posedge clk_i);
		i_chk.end_test(name, reqs);
	endtask

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin
		addr_t a;
		data_t wd;
		int    k;
		rst_i       = 1'b1;
		q_req_i     = 1'b0;
		q_tag_i     = '0;
		q_load_i    = 1'b0;
		q_size_i    = '0;
		q_addr_i    = '0;
		q_wdata_i   = '0;
		mem_ack_i   = 1'b0;
		mem_rdat_i  = '0;
		stomp_i     = 1'b0;
		stomp_tag_i = '0;
		next_tag    = '0;
		for (k = 0; k < MEM_BYTES; k++) begin
			model_mem[k]  = fill_byte(addr_t'(k));
			shadow_mem[k] = fill_byte(addr_t'(k));
		end
		repeat (3) @(posedge clk_i);
		rst_i <= 1'b0;

		// Aligned words written then read back, one bus phase each
		i_chk.begin_test();
		for (k = 0; k < 8; k++) begin
			a  = addr_t'($random(seed)) & 32'h0000_3ff8;
			wd = {$random(seed), $random(seed)};
			run_access(1'b0, 2'd3, a, wd, 1'b0);
			run_access(1'b1, 2'd3, a, '0, 1'b0);
		end
		close_test("aligned store and load", 16);

		// Four bytes spilling into the next word, two phases each
		i_chk.begin_test();
		for (k = 5; k < 8; k++) begin
			a  = 32'h0000_0840 + addr_t'(k);
			wd = {$random(seed), $random(seed)};
			run_access(1'b0, 2'd2, a, wd, 1'b0);
			run_access(1'b1, 2'd2, a, '0, 1'b0);
		end
		close_test("unaligned access over two words", 12);

		i_chk.begin_test();
		run_access(1'b1, 2'd2, 32'h0000_1ffe, '0, 1'b0);
		run_access(1'b0, 2'd3, 32'h0000_2ffc, 64'h0123_4567_89ab_cdef, 1'b0);
		close_test("page crossing", 0);

		i_chk.begin_test();
		run_access(1'b1, 2'd3, 32'h8000_0100, '0, 1'b0);
		close_test("bus timeout", 1);

		// Stomped two-phase load, then the same load to completion
		i_chk.begin_test();
		run_access(1'b1, 2'd3, 32'h0000_0a03, '0, 1'b1);
		run_access(1'b1, 2'd3, 32'h0000_0a03, '0, 1'b0);
		close_test("stomp of the active tag", 4);

		i_chk.begin_test();
		for (k = 0; k < 200; k++) begin
			a  = addr_t'($random(seed)) & 32'h0000_3fff;
			wd = {$random(seed), $random(seed)};
			run_access(1'($random(seed)), size_t'($random(seed)), a, wd, 1'b0);
		end
		close_test("random mix", -1);

		// Lanes, addresses and data of every store, including those never loaded back
		i_chk.begin_test();
		compare_images();
		close_test("memory image after stores", -1);

		i_chk.print_counts();
		if (i_chk.error_total() == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
logic/mem_slot_pkg.sv
logic/mem_slot_seq.sv
logic/mem_slot_work.sv
logic/mem_slot_oper.sv
logic/mem_slot_top.sv
sim/mem_slot_checker.sv
sim/tb_mem_slot.sv
